/* src/bitmanip_pkg.sv */
// Operand width, RV32 opcode and funct constants, clmul iteration sizes
// Instruction word with R-type and I-type views, unit select and issue bundles
`default_nettype none

package bitmanip_pkg;
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [6:0] F7_INV         = 7'b0100000; // ANDN, ORN, XNOR
	localparam logic [6:0] F7_MINMAX      = 7'b0000101;
	localparam logic [6:0] F7_CLMUL_GROUP = 7'b0000101; // Shared with min/max, funct3 splits
	localparam logic [6:0] F7_BITCNT      = 7'b0110000; // Upper imm12 bits of the counts

	localparam logic [4:0] CNT_CLZ  = 5'd0;
	localparam logic [4:0] CNT_CTZ  = 5'd1;
	localparam logic [4:0] CNT_PCNT = 5'd2;

	localparam int CLMUL_BITS_PER_CYCLE = 4;
	localparam int CLMUL_STEPS          = XLEN / CLMUL_BITS_PER_CYCLE;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} insn_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} insn_i_t;

	typedef union packed {
		insn_r_t r_view;
		insn_i_t i_view;
	} insn_t;

	typedef struct packed {
		logic logic_op;
		logic bitcnt;
		logic clmul;
	} unit_sel_t;

	typedef struct packed {
		xlen_t rs1;
		xlen_t rs2;
		insn_t insn;
	} issue_op_t;
endpackage

`default_nettype wire

/* src/bitmanip_decoder.sv */
// Instruction decoder, picks the functional unit for a kept RV32 bitmanip op
`timescale 1ns/1ps
`default_nettype none

module bitmanip_decoder (
	input  bitmanip_pkg::insn_t     insn,
	output bitmanip_pkg::unit_sel_t sel
);
	import bitmanip_pkg::*;

	logic is_op;
	logic is_op_imm;

	assign is_op     = insn.r_view.opcode == OPC_OP;
	assign is_op_imm = insn.i_view.opcode == OPC_OP_IMM;

	always_comb begin
		sel = '0;

		if (is_op && insn.r_view.funct7 == F7_INV) begin
			case (insn.r_view.funct3)
				3'b111, 3'b110, 3'b100: sel.logic_op = 1'b1; // ANDN, ORN, XNOR
				default: ;
			endcase
		end

		// funct3 100..111 are min/max, 001..011 the clmul family
		if (is_op && insn.r_view.funct7 == F7_MINMAX && insn.r_view.funct3[2])
			sel.logic_op = 1'b1;
		if (is_op && insn.r_view.funct7 == F7_CLMUL_GROUP) begin
			case (insn.r_view.funct3)
				3'b001, 3'b010, 3'b011: sel.clmul = 1'b1;
				default: ;
			endcase
		end

		// Counts are I-type, selector sits in the low imm12 bits
		if (is_op_imm && insn.i_view.funct3 == 3'b001 &&
				insn.i_view.imm12[11:5] == F7_BITCNT) begin
			case (insn.i_view.imm12[4:0])
				CNT_CLZ, CNT_CTZ, CNT_PCNT: sel.bitcnt = 1'b1;
				default: ;
			endcase
		end
	end

	assert #0 ($onehot0(sel))
		else $error("decoder selected more than one unit");
endmodule

`default_nettype wire

/* src/issue_stage.sv */
// Issue stage: input handshake, operand latch, per-unit pending flags
// and the busy arbiter that keeps one instruction in flight
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    din_valid,
	input  bitmanip_pkg::xlen_t     din_rs1,
	input  bitmanip_pkg::xlen_t     din_rs2,
	input  bitmanip_pkg::insn_t     din_insn,
	input  bitmanip_pkg::unit_sel_t sel,
	input  bitmanip_pkg::unit_sel_t unit_ready,
	input  logic                    retire,
	output logic                    din_ready,
	output logic                    din_decoded,
	output bitmanip_pkg::unit_sel_t pending,
	output bitmanip_pkg::issue_op_t op
);
	logic busy_reg;
	logic busy;
	logic take;

	assign din_decoded = |sel;
	assign busy        = busy_reg && !retire; // Idle again in the retire cycle
	assign din_ready   = !reset && !busy && din_decoded;
	assign take        = din_valid && din_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_reg <= 1'b0;
			pending  <= '0;
		end else begin
			busy_reg <= busy || take;
			if (take)
				pending <= sel;
			else
				pending <= pending & ~unit_ready; // Unit took it
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			op.rs1  <= din_rs1;
			op.rs2  <= din_rs2;
			op.insn <= din_insn;
		end
	end

	assert property (@(posedge clock) disable iff (reset) $onehot0(pending))
		else $error("more than one unit pending");
endmodule

`default_nettype wire

/* src/logic_minmax_unit.sv */
// Inverted logic ops (ANDN, ORN, XNOR) and signed/unsigned min/max
// Single-cycle, result registered and held until accepted
`timescale 1ns/1ps
`default_nettype none

module logic_minmax_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    pending_logic,
	input  bitmanip_pkg::issue_op_t op,
	input  logic                    accept,
	output logic                    ready,
	output logic                    valid,
	output bitmanip_pkg::xlen_t     result
);
	import bitmanip_pkg::*;

	xlen_t rs1;
	xlen_t rs2;
	xlen_t next_result;
	logic  lt_s;
	logic  lt_u;

	assign rs1  = op.rs1;
	assign rs2  = op.rs2;
	assign lt_s = $signed(rs1) < $signed(rs2);
	assign lt_u = rs1 < rs2;

	always_comb begin
		if (op.insn.r_view.funct7 == F7_INV) begin
			case (op.insn.r_view.funct3)
				3'b111:  next_result = rs1 & ~rs2; // ANDN
				3'b110:  next_result = rs1 | ~rs2; // ORN
				default: next_result = rs1 ^ ~rs2; // XNOR
			endcase
		end else begin
			case (op.insn.r_view.funct3[1:0])
				2'b00:   next_result = lt_s ? rs1 : rs2; // MIN
				2'b01:   next_result = lt_s ? rs2 : rs1; // MAX
				2'b10:   next_result = lt_u ? rs1 : rs2; // MINU
				default: next_result = lt_u ? rs2 : rs1; // MAXU
			endcase
		end
	end

	assign ready = !valid;

	always_ff @(posedge clock) begin
		if (reset)
			valid <= 1'b0;
		else if (pending_logic && ready)
			valid <= 1'b1;
		else if (accept)
			valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (pending_logic && ready)
			result <= next_result;
	end
endmodule

`default_nettype wire

/* src/bitcount_unit.sv */
// Leading zeros, trailing zeros and population count of rs1
// Single-cycle, result registered and held until accepted
`timescale 1ns/1ps
`default_nettype none

module bitcount_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    pending_bitcnt,
	input  bitmanip_pkg::issue_op_t op,
	input  logic                    accept,
	output logic                    ready,
	output logic                    valid,
	output bitmanip_pkg::xlen_t     result
);
	import bitmanip_pkg::*;

	xlen_t clz;
	xlen_t ctz;
	xlen_t pcnt;

	// Zero operand leaves both counts at XLEN
	always_comb begin
		clz  = XLEN;
		ctz  = XLEN;
		pcnt = '0;
		for (int i = 0; i < XLEN; i++) begin
			if (op.rs1[i]) begin
				clz  = XLEN - 1 - i; // Last hit is the MSB
				pcnt = pcnt + 1'b1;
			end
			if (op.rs1[XLEN-1-i])
				ctz = XLEN - 1 - i; // Last hit is the LSB
		end
	end

	assign ready = !valid;

	always_ff @(posedge clock) begin
		if (reset)
			valid <= 1'b0;
		else if (pending_bitcnt && ready)
			valid <= 1'b1;
		else if (accept)
			valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (pending_bitcnt && ready) begin
			case (op.insn.i_view.imm12[4:0])
				CNT_CLZ: result <= clz;
				CNT_CTZ: result <= ctz;
				default: result <= pcnt;
			endcase
		end
	end
endmodule

`default_nettype wire

/* src/clmul_unit.sv */
// Iterative carry-less multiplier, a few rs2 bits per cycle into a 64-bit product
// Output is the low word, high word or reversed window, chosen by funct3
`timescale 1ns/1ps
`default_nettype none

module clmul_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    pending_clmul,
	input  bitmanip_pkg::issue_op_t op,
	input  logic                    accept,
	output logic                    ready,
	output logic                    valid,
	output bitmanip_pkg::xlen_t     result
);
	import bitmanip_pkg::*;

	logic [2*XLEN-1:0] product;
	logic [2*XLEN-1:0] mcand; // rs1, shifted up as bits are consumed
	logic [2*XLEN-1:0] next_product;
	xlen_t             mplier;
	logic [2:0]        funct3;
	logic [$clog2(CLMUL_STEPS+1)-1:0] step;
	logic              busy;
	logic              start;

	assign ready = !busy && !valid;
	assign start = pending_clmul && ready;

	always_comb begin
		next_product = product;
		for (int i = 0; i < CLMUL_BITS_PER_CYCLE; i++) begin
			if (mplier[i])
				next_product = next_product ^ (mcand << i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			valid <= 1'b0;
			step  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= step + 1'b1;
			if (step == CLMUL_STEPS - 1) begin
				busy  <= 1'b0;
				valid <= 1'b1;
			end
		end else if (accept) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			product <= '0;
			mcand   <= {{XLEN{1'b0}}, op.rs1};
			mplier  <= op.rs2;
			funct3  <= op.insn.r_view.funct3;
		end else if (busy) begin
			product <= next_product;
			mcand   <= mcand << CLMUL_BITS_PER_CYCLE;
			mplier  <= mplier >> CLMUL_BITS_PER_CYCLE;
		end
	end

	always_comb begin
		case (funct3)
			3'b011:  result = product[2*XLEN-1:XLEN];   // CLMULH
			3'b010:  result = product[2*XLEN-2:XLEN-1]; // CLMULR
			default: result = product[XLEN-1:0];        // CLMUL
		endcase
	end

	assert property (@(posedge clock) disable iff (reset) step <= CLMUL_STEPS)
		else $error("clmul step counter overran");
endmodule

`default_nettype wire

/* src/result_stage.sv */
// Output register, selection among the unit results, back-pressure and retire
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  bitmanip_pkg::unit_sel_t unit_valid,
	input  bitmanip_pkg::xlen_t     logic_result,
	input  bitmanip_pkg::xlen_t     bitcnt_result,
	input  bitmanip_pkg::xlen_t     clmul_result,
	input  logic                    dout_ready,
	output logic                    accept,
	output logic                    retire,
	output logic                    dout_valid,
	output bitmanip_pkg::xlen_t     dout_rd
);
	assign accept = !dout_valid || dout_ready; // Empty or draining this cycle
	assign retire = accept && |unit_valid;

	always_ff @(posedge clock) begin
		if (reset)
			dout_valid <= 1'b0;
		else if (retire)
			dout_valid <= 1'b1;
		else if (dout_ready)
			dout_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			case (1'b1)
				unit_valid.logic_op: dout_rd <= logic_result;
				unit_valid.bitcnt:   dout_rd <= bitcnt_result;
				default:             dout_rd <= clmul_result;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) $onehot0(unit_valid))
		else $error("more than one unit result valid");
endmodule

`default_nettype wire

/* src/bitmanip_unit.sv */
// Top level of the RV32 bitmanip coprocessor: decoder, issue stage,
// logic/minmax, bitcount and clmul units, result stage
`timescale 1ns/1ps
`default_nettype none

module bitmanip_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                din_valid,
	input  bitmanip_pkg::xlen_t din_rs1,
	input  bitmanip_pkg::xlen_t din_rs2,
	input  bitmanip_pkg::insn_t din_insn,
	input  logic                dout_ready,
	output logic                din_ready,
	output logic                din_decoded,
	output logic                dout_valid,
	output bitmanip_pkg::xlen_t dout_rd
);
	import bitmanip_pkg::*;

	unit_sel_t      sel;
	unit_sel_t      pending;
	wire unit_sel_t unit_ready;
	wire unit_sel_t unit_valid;
	issue_op_t      op;
	xlen_t          logic_result;
	xlen_t          bitcnt_result;
	xlen_t          clmul_result;
	logic           accept;
	logic           retire;

	bitmanip_decoder decoder_inst (
		.insn(din_insn),
		.sel (sel)
	);

	issue_stage issue_inst (
		.clock      (clock),
		.reset      (reset),
		.din_valid  (din_valid),
		.din_rs1    (din_rs1),
		.din_rs2    (din_rs2),
		.din_insn   (din_insn),
		.sel        (sel),
		.unit_ready (unit_ready),
		.retire     (retire),
		.din_ready  (din_ready),
		.din_decoded(din_decoded),
		.pending    (pending),
		.op         (op)
	);

	logic_minmax_unit logic_inst (
		.clock        (clock),
		.reset        (reset),
		.pending_logic(pending.logic_op),
		.op           (op),
		.accept       (accept),
		.ready        (unit_ready.logic_op),
		.valid        (unit_valid.logic_op),
		.result       (logic_result)
	);

	bitcount_unit bitcnt_inst (
		.clock         (clock),
		.reset         (reset),
		.pending_bitcnt(pending.bitcnt),
		.op            (op),
		.accept        (accept),
		.ready         (unit_ready.bitcnt),
		.valid         (unit_valid.bitcnt),
		.result        (bitcnt_result)
	);

	clmul_unit clmul_inst (
		.clock        (clock),
		.reset        (reset),
		.pending_clmul(pending.clmul),
		.op           (op),
		.accept       (accept),
		.ready        (unit_ready.clmul),
		.valid        (unit_valid.clmul),
		.result       (clmul_result)
	);

	result_stage result_inst (
		.clock        (clock),
		.reset        (reset),
		.unit_valid   (unit_valid),
		.logic_result (logic_result),
		.bitcnt_result(bitcnt_result),
		.clmul_result (clmul_result),
		.dout_ready   (dout_ready),
		.accept       (accept),
		.retire       (retire),
		.dout_valid   (dout_valid),
		.dout_rd      (dout_rd)
	);
endmodule

`default_nettype wire

/* test/bitmanip_unit_tb.sv */
// Trace-driven testbench for bitmanip_unit with random output back-pressure
// Checks decode flags, in-order results, stall stability and single issue
`timescale 1ns/1ps
`default_nettype none

module bitmanip_unit_tb;
	import bitmanip_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic  clock;
	logic  reset;
	logic  din_valid;
	xlen_t din_rs1;
	xlen_t din_rs2;
	insn_t din_insn;
	logic  dout_ready;
	logic  din_ready;
	logic  din_decoded;
	logic  dout_valid;
	xlen_t dout_rd;

	int    error_count;
	int    accepted;
	int    transferred;
	string name_q[$]; // Test names of accepted instructions
	xlen_t rd_q[$];   // Their expected results in issue order

	bitmanip_unit bitmanip_unit_inst (
		.clock      (clock),
		.reset      (reset),
		.din_valid  (din_valid),
		.din_rs1    (din_rs1),
		.din_rs2    (din_rs2),
		.din_insn   (din_insn),
		.dout_ready (dout_ready),
		.din_ready  (din_ready),
		.din_decoded(din_decoded),
		.dout_valid (dout_valid),
		.dout_rd    (dout_rd)
	);

	always #4 clock = ~clock;

	// Random back-pressure on the output side
	initial begin
		void'($urandom(32'hebb3));
		forever begin
			@(negedge clock);
			dout_ready <= ($urandom % 4) != 0; // Ready about three cycles in four
		end
	end

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Present one trace line and wait for acceptance or confirm rejection
	task automatic run_line(input string name, input insn_t insn, input xlen_t rs1,
			input xlen_t rs2, input logic decodable, input xlen_t expected);
		int waited;

		@(negedge clock);
		din_insn  = insn;
		din_rs1   = rs1;
		din_rs2   = rs2;
		din_valid = 1'b1;
		#1;
		check_flag(name, decodable, din_decoded);
		waited = 0;
		if (!decodable) begin
			while (!din_ready && waited < TIMEOUT_CYCLES) begin
				@(negedge clock);
				#1;
				waited++;
			end
			if (din_ready) begin
				$display("%s: din_ready went high for an undecodable instruction", name);
				error_count++;
			end
		end else begin
			while (!din_ready && waited < TIMEOUT_CYCLES) begin
				@(negedge clock);
				#1;
				waited++;
			end
			if (din_ready) begin
				@(posedge clock); // Acceptance edge
				name_q.push_back(name);
				rd_q.push_back(expected);
				accepted++;
			end else begin
				$display("%s: timed out waiting for din_ready", name);
				error_count++;
			end
		end
		@(negedge clock);
		din_valid = 1'b0;
	endtask

	// Output side sampled mid-cycle
	initial begin
		logic  stalled;
		logic  expect_load;
		xlen_t held_rd;
		string name;
		xlen_t expected;
		int    unretired;

		stalled     = 1'b0;
		expect_load = 1'b0;
		held_rd     = '0;
		forever begin
			@(negedge clock);
			#2;
			if (!reset) begin
				if (stalled) begin
					check_flag("stall_valid", 1'b1, dout_valid);
					check_word("stall_rd", held_rd, dout_rd);
				end
				if (expect_load)
					check_flag("retire_load", 1'b1, dout_valid);
				expect_load = 1'b0;
				unretired   = accepted - transferred - int'(dout_valid);
				if (din_ready) begin
					if (unretired > 1 || (unretired == 1 && dout_valid && !dout_ready)) begin
						$display("din_ready high with %0d results still unretired",
							unretired);
						error_count++;
					end else if (unretired == 1) begin
						expect_load = 1'b1; // Only legal in the retire cycle
					end
				end
				if (dout_valid && dout_ready) begin
					if (rd_q.size() == 0) begin
						$display("result %h appeared with no instruction outstanding", dout_rd);
						error_count++;
					end else begin
						name     = name_q.pop_front();
						expected = rd_q.pop_front();
						check_word(name, expected, dout_rd);
					end
					transferred++;
				end
				stalled = dout_valid && !dout_ready;
				held_rd = dout_rd;
			end
		end
	end

	initial begin
		int          fd;
		int          n;
		int          ch;
		int          waited;
		int          decodable;
		string       name;
		logic [31:0] insn_v;
		xlen_t       rs1_v;
		xlen_t       rs2_v;
		xlen_t       rd_v;

		clock       = 1'b0;
		reset       = 1'b1;
		din_valid   = 1'b0;
		din_rs1     = '0;
		din_rs2     = '0;
		din_insn    = '0;
		dout_ready  = 1'b0;
		error_count = 0;
		accepted    = 0;
		transferred = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		fd = $fopen("test/bitmanip_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
			error_count++;
		end
		while (fd != 0 && $fscanf(fd, "%s", name) == 1) begin
			if (name.substr(0, 0) == "#") begin
				ch = $fgetc(fd); // Skip the rest of a comment line
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else begin
				n = $fscanf(fd, "%h %h %h %d %h", insn_v, rs1_v, rs2_v, decodable, rd_v);
				if (n != 5) begin
					$display("%s: malformed trace line", name);
					error_count++;
				end else begin
					run_line(name, insn_v, rs1_v, rs2_v, decodable != 0, rd_v);
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		waited = 0;
		while (rd_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		if (rd_q.size() != 0) begin
			$display("timed out with %0d results never delivered", rd_q.size());
			error_count++;
		end
		repeat (4) @(negedge clock); // Room for a stray extra result
		if (accepted != transferred) begin
			$display("%0d instructions accepted but %0d results seen", accepted, transferred);
			error_count++;
		end

		$display("errors: %0d, accepted: %0d, results: %0d", error_count, accepted, transferred);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end
endmodule

`default_nettype wire

/* test/bitmanip_trace.txt */
# Columns: name insn rs1 rs2 decodable expected_rd
# Numbers in hex except decodable (1 = kept instruction, 0 = rejected)
andn_mixed 40c5f533 f0f01234 0ff000ff 1 f0001200
orn_mixed 40c5e533 f0f01234 0ff000ff 1 f0ffff34
xnor_mixed 40c5c533 f0f01234 0ff000ff 1 00ffed34
min_sign 0ac5c533 80000000 00000001 1 80000000
max_sign 0ac5d533 80000000 00000001 1 00000001
minu_sign 0ac5e533 80000000 00000001 1 00000001
maxu_sign 0ac5f533 80000000 00000001 1 80000000
min_equal 0ac5c533 deadbeef deadbeef 1 deadbeef
max_neg 0ac5d533 ffffffff fffffffe 1 ffffffff
sll_illegal 00c59533 00000001 00000004 0 00000000
clz_mid 60059513 00010000 00000000 1 0000000f
clz_zero 60059513 00000000 00000000 1 00000020
clz_ones 60059513 ffffffff 00000000 1 00000000
ctz_mid 60159513 00010000 00000000 1 00000010
ctz_zero 60159513 00000000 00000000 1 00000020
pcnt_ones 60259513 ffffffff 00000000 1 00000020
pcnt_mixed 60259513 f0f01234 00000000 1 0000000d
clmul_small 0ac59533 00000005 00000007 1 0000001b
clmul_wrap 0ac59533 80000001 80000001 1 00000001
clmulh_wrap 0ac5b533 80000001 80000001 1 40000000
clmulr_wrap 0ac5a533 80000001 80000001 1 80000000
clmulh_ones 0ac5b533 ffffffff 00000002 1 00000001
clmulr_ones 0ac5a533 ffffffff 00000002 1 00000003
add_illegal 00c58533 00000003 00000004 0 00000000

/* bitmanip_unit.f */
src/bitmanip_pkg.sv
src/bitmanip_decoder.sv
src/issue_stage.sv
src/logic_minmax_unit.sv
src/bitcount_unit.sv
src/clmul_unit.sv
src/result_stage.sv
src/bitmanip_unit.sv
test/bitmanip_unit_tb.sv
